/* i2s_capture.f */
rtl/i2s_pkg.sv
rtl/i2s_deserializer.sv
rtl/sample_fifo.sv
rtl/i2s_receiver.sv
rtl/i2s_receiver_array.sv
tests/i2s_receiver_array_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --timescale 1ns/1ns
TOP      = i2s_receiver_array_tb
RTL_TOP  = i2s_receiver_array
FILELIST = i2s_capture.f
OBJ_DIR  = obj_dir
PASS_MSG = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/i2s_patterns.mem */
// receiver  left sample  right sample, one I2S frame per line
// groups are consumed in testbench order
// capture, alternating receivers
0 a5c3e1 5a3c1e
1 123456 fedcba
0 800001 7ffffe
1 0f0f0f f0f0f0
0 000000 ffffff
1 c0ffee 0badf0
0 314159 271828
1 aaaaaa 555555
// output ready on receiver 0
0 100001 200002
0 300003 400004
0 500005 600006
0 700007 800008
0 900009 a0000a
// overflow on receiver 1
1 b00001 b10001
1 b00002 b10002
1 b00003 b10003
1 b00004 b10004
1 b00005 b10005
1 b00006 b10006
1 b00007 b10007
1 b00008 b10008
1 b00009 b10009
1 b0000a b1000a
1 b0000b b1000b
1 b0000c b1000c
// chip select isolation
0 d00001 e00001
1 d10002 e10002
0 d00003 e00003
1 d10004 e10004
0 d00005 e00005
1 d10006 e10006

/* tests/i2s_receiver_array_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_receiver_array_tb;

	import i2s_pkg::*;

	localparam int NUM_FRAMES      = 31;
	localparam int HALF_BITS       = 32;
	localparam int BCLK_HALF       = 4;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * 64 * 8 + 4000;

	logic              clk;
	logic              rst;
	logic [RX_NUM-1:0] bclk;
	logic [RX_NUM-1:0] lrclk;
	logic [RX_NUM-1:0] sdata;
	logic              read_enable;
	logic [RX_NUM-1:0] chip_select;
	logic [RX_NUM-1:0] output_ready;
	logic [RX_NUM-1:0] buffer_full_error;
	logic [RX_NUM-1:0] buffer_empty_error;
	logic [RX_NUM-1:0] local_read_enable;
	rx_word_t          rdata;
	logic              s_data_valid;
	mon_sample_t       i2s_received_data;

	// three entries per frame for receiver, left and right
	logic [23:0] patterns [NUM_FRAMES*3];
	logic [31:0] exp_words [RX_NUM][$];
	logic [24:0] exp_mon [$];
	logic [31:0] last_rdata;
	int          full_pulses [RX_NUM];
	int          full_base;
	int          pat_idx;
	int          checks = 0;
	int          errors = 0;
	int          test_err_base = 0;

	i2s_receiver_array dut_i (
		.clk               (clk),
		.rst               (rst),
		.bclk              (bclk),
		.lrclk             (lrclk),
		.sdata             (sdata),
		.read_enable       (read_enable),
		.chip_select       (chip_select),
		.output_ready      (output_ready),
		.buffer_full_error (buffer_full_error),
		.buffer_empty_error(buffer_empty_error),
		.local_read_enable (local_read_enable),
		.rdata             (rdata),
		.s_data_valid      (s_data_valid),
		.i2s_received_data (i2s_received_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_err_base);
		test_err_base = errors;
	endtask

	// host word layout of id, channel, two zero bits and sample
	function automatic logic [31:0] pack_word(input int rx, input logic right,
			input logic [23:0] smp);
		return {rx[4:0], right, 2'b00, smp};
	endfunction

	task automatic model_push(input int rx, input logic right, input logic [23:0] smp);
		if (exp_words[rx].size() < FIFO_DEPTH) begin
			exp_words[rx].push_back(pack_word(rx, right, smp));
		end
	endtask

	// data changes on bclk fall with the MSB one slot after the lrclk change
	task automatic drive_frame(input int rx, input logic [23:0] left_smp,
			input logic [23:0] right_smp);
		logic [23:0] smp;
		logic        prev_lsb;
		prev_lsb = 1'b0;
		for (int half = 0; half < 2; half++) begin
			smp = (half == 0) ? left_smp : right_smp;
			for (int k = 0; k < HALF_BITS; k++) begin
				bclk[rx]  = 1'b0;
				lrclk[rx] = half[0];
				if (k == 0) begin
					sdata[rx] = prev_lsb;
				end else if (k <= SAMPLE_W) begin
					sdata[rx] = smp[SAMPLE_W - k];
				end else begin
					sdata[rx] = 1'b0;
				end
				repeat (BCLK_HALF) @(negedge clk);
				bclk[rx] = 1'b1;
				repeat (BCLK_HALF) @(negedge clk);
			end
			prev_lsb = smp[0];
		end
		bclk[rx] = 1'b0;
	endtask

	task automatic send_frames(input int n);
		int          rx;
		logic [23:0] left_smp;
		logic [23:0] right_smp;
		for (int i = 0; i < n; i++) begin
			rx        = int'(patterns[pat_idx*3]);
			left_smp  = patterns[pat_idx*3+1];
			right_smp = patterns[pat_idx*3+2];
			pat_idx++;
			model_push(rx, 1'b0, left_smp);
			model_push(rx, 1'b1, right_smp);
			if (rx == 0) begin
				exp_mon.push_back({1'b0, left_smp});
				exp_mon.push_back({1'b1, right_smp});
			end
			drive_frame(rx, left_smp, right_smp);
		end
	endtask

	// chip select is held one cycle past the strobe
	task automatic read_word(input int rx);
		logic [RX_NUM-1:0] sel;
		logic [31:0]       expected;
		logic              was_empty;
		int                gap;
		sel       = '0;
		sel[rx]   = 1'b1;
		was_empty = exp_words[rx].size() == 0;
		expected  = was_empty ? last_rdata : exp_words[rx].pop_front();
		gap       = int'($urandom % 4);
		read_enable = 1'b1;
		chip_select = sel;
		@(posedge clk);
		check_value("local_read_enable", 32'(local_read_enable), 32'(sel));
		@(negedge clk);
		check_value("buffer_empty_error", 32'(buffer_empty_error),
			was_empty ? 32'(sel) : 32'(0));
		read_enable = 1'b0;
		@(posedge clk);
		check_value("local_read_enable", 32'(local_read_enable), 32'(0));
		@(negedge clk);
		chip_select = '0;
		check_value("rdata", rdata, expected);
		last_rdata = expected;
		repeat (gap) @(negedge clk);
	endtask

	task automatic read_words(input int rx, input int n);
		for (int i = 0; i < n; i++) begin
			read_word(rx);
		end
	endtask

	task automatic drain(input int rx);
		while (exp_words[rx].size() > 0) begin
			read_word(rx);
		end
	endtask

	task automatic check_ready(input int rx);
		@(negedge clk);
		check_value("output_ready", 32'(output_ready[rx]),
			32'(exp_words[rx].size() >= OUT_WORDS));
	endtask

	// receiver 0 monitor and full pulse counting
	always @(negedge clk) begin
		if (rst) begin
			if (s_data_valid) begin
				if (exp_mon.size() == 0) begin
					report_failure("s_data_valid pulsed with no sample pending");
				end else begin
					check_value("i2s_received_data", 32'(i2s_received_data),
						32'(exp_mon.pop_front()));
				end
			end
			for (int i = 0; i < RX_NUM; i++) begin
				if (buffer_full_error[i]) begin
					full_pulses[i]++;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h744e));
		rst         = 1'b0;
		bclk        = '0;
		lrclk       = '0;
		sdata       = '0;
		read_enable = 1'b0;
		chip_select = '0;
		pat_idx     = 0;
		last_rdata  = '0;
		full_pulses = '{default: 0};
		$readmemh("tests/i2s_patterns.mem", patterns);
		repeat (5) @(negedge clk);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		check_value("rdata", rdata, 32'(0));
		check_value("output_ready", 32'(output_ready), 32'(0));
		check_value("buffer_full_error", 32'(buffer_full_error), 32'(0));
		check_value("buffer_empty_error", 32'(buffer_empty_error), 32'(0));
		check_value("s_data_valid", 32'(s_data_valid), 32'(0));
		end_test("reset");

		send_frames(8);
		drain(0);
		drain(1);
		end_test("capture");

		send_frames(3);
		check_ready(0);
		read_words(0, 1);
		send_frames(1);
		check_ready(0);
		send_frames(1);
		check_ready(0);
		read_words(0, 2);
		check_ready(0);
		drain(0);
		end_test("output_ready");

		full_base = full_pulses[1];
		send_frames(12);
		check_value("buffer_full_error seen", 32'(full_pulses[1] > full_base), 32'(1));
		check_ready(1);
		drain(1);
		end_test("overflow");

		read_word(1);
		read_word(0);
		end_test("empty_read");

		send_frames(6);
		drain(1);
		drain(0);
		end_test("isolation");

		repeat (10) @(negedge clk);
		check_value("pending monitor samples", 32'(exp_mon.size()), 32'(0));
		check_value("rx0 full pulses", 32'(full_pulses[0]), 32'(0));
		end_test("monitor");

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/i2s_receiver_array.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_receiver_array (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [i2s_pkg::RX_NUM-1:0] bclk,
	input  logic [i2s_pkg::RX_NUM-1:0] lrclk,
	input  logic [i2s_pkg::RX_NUM-1:0] sdata,
	input  logic                        read_enable,
	input  logic [i2s_pkg::RX_NUM-1:0] chip_select,
	output logic [i2s_pkg::RX_NUM-1:0] output_ready,
	output logic [i2s_pkg::RX_NUM-1:0] buffer_full_error,
	output logic [i2s_pkg::RX_NUM-1:0] buffer_empty_error,
	output logic [i2s_pkg::RX_NUM-1:0] local_read_enable,
	output i2s_pkg::rx_word_t          rdata,
	output logic                        s_data_valid,
	output i2s_pkg::mon_sample_t       i2s_received_data
);

	import i2s_pkg::*;

	rx_word_t    rx_rdata [RX_NUM];
	mon_sample_t rx_mon [RX_NUM];
	logic [RX_NUM-1:0] rx_mon_valid;

	logic     read_enable_q;
	logic     sel_hit;
	rx_word_t sel_word;

	assign local_read_enable = chip_select & {RX_NUM{read_enable}};

	for (genvar g = 0; g < RX_NUM; g++) begin : g_rx
		i2s_receiver #(
			.ID(g)
		) rx_i (
			.clk               (clk),
			.rst               (rst),
			.bclk              (bclk[g]),
			.lrclk             (lrclk[g]),
			.sdata             (sdata[g]),
			.read_enable       (local_read_enable[g]),
			.rdata             (rx_rdata[g]),
			.output_ready      (output_ready[g]),
			.buffer_full_error (buffer_full_error[g]),
			.buffer_empty_error(buffer_empty_error[g]),
			.s_data_valid      (rx_mon_valid[g]),
			.i2s_received_data (rx_mon[g])
		);
	end

	// lowest selected receiver wins, an empty pop takes nothing
	always_comb begin
		sel_hit  = 1'b0;
		sel_word = '0;
		for (int i = RX_NUM - 1; i >= 0; i--) begin
			if (chip_select[i]) begin
				sel_hit  = ~buffer_empty_error[i];
				sel_word = rx_rdata[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			read_enable_q <= 1'b0;
			rdata         <= '0;
		end else begin
			read_enable_q <= read_enable;
			if (read_enable_q && sel_hit) begin
				rdata <= sel_word;
			end
		end
	end

	assign s_data_valid      = rx_mon_valid[0];
	assign i2s_received_data = rx_mon[0];

endmodule

`default_nettype wire

/* rtl/i2s_receiver.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_receiver #(
	parameter int ID = 0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 bclk,
	input  logic                 lrclk,
	input  logic                 sdata,
	input  logic                 read_enable,
	output i2s_pkg::rx_word_t    rdata,
	output logic                 output_ready,
	output logic                 buffer_full_error,
	output logic                 buffer_empty_error,
	output logic                 s_data_valid,
	output i2s_pkg::mon_sample_t i2s_received_data
);

	import i2s_pkg::*;

	logic               sample_valid;
	mon_sample_t        mon;
	rx_word_t           word;
	rx_word_t           head;
	logic [LEVEL_W-1:0] level;

	i2s_deserializer deser_i (
		.clk         (clk),
		.rst         (rst),
		.bclk        (bclk),
		.lrclk       (lrclk),
		.sdata       (sdata),
		.sample_valid(sample_valid),
		.sample      (mon)
	);

	assign word = '{id: ID_W'(ID), right: mon.right, pad: '0, sample: mon.sample};

	sample_fifo fifo_i (
		.clk      (clk),
		.rst      (rst),
		.push     (sample_valid),
		.push_word(word),
		.pop      (read_enable),
		.head     (head),
		.level    (level),
		.full_err (buffer_full_error),
		.empty_err(buffer_empty_error)
	);

	always_ff @(posedge clk) begin
		if (!rst) begin
			rdata        <= '0;
			output_ready <= 1'b0;
		end else begin
			output_ready <= level >= LEVEL_W'(OUT_WORDS);
			// an empty pop leaves the last word in place
			if (read_enable && level != '0) begin
				rdata <= head;
			end
		end
	end

	assign s_data_valid      = sample_valid;
	assign i2s_received_data = mon;

endmodule

`default_nettype wire

/* rtl/sample_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_fifo (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           push,
	input  i2s_pkg::rx_word_t              push_word,
	input  logic                           pop,
	output i2s_pkg::rx_word_t              head,
	output logic [i2s_pkg::LEVEL_W-1:0]    level,
	output logic                           full_err,
	output logic                           empty_err
);

	import i2s_pkg::*;

	rx_word_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [LEVEL_W-1:0] count;

	logic full;
	logic empty;
	logic push_ok;
	logic pop_ok;

	assign full    = count == LEVEL_W'(FIFO_DEPTH);
	assign empty   = count == '0;
	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			full_err  <= 1'b0;
			empty_err <= 1'b0;
		end else begin
			full_err  <= push & full;
			empty_err <= pop & empty;
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head  = mem[rd_ptr];
	assign level = count;

endmodule

`default_nettype wire

/* rtl/i2s_deserializer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_deserializer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 bclk,
	input  logic                 lrclk,
	input  logic                 sdata,
	output logic                 sample_valid,
	output i2s_pkg::mon_sample_t sample
);

	import i2s_pkg::*;

	logic [1:0]          bclk_s;
	logic [1:0]          lrclk_s;
	logic [1:0]          sdata_s;
	logic                bclk_d;
	logic                lr_last;
	logic                shifting;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [SAMPLE_W-1:0] shift_reg;
	logic                chan;

	logic bclk_rise;
	logic lr_change;
	logic last_bit;

	assign bclk_rise = bclk_s[1] & ~bclk_d;
	assign lr_change = lrclk_s[1] != lr_last;
	assign last_bit  = bit_cnt == BIT_CNT_W'(SAMPLE_W - 1);

	always_ff @(posedge clk) begin
		if (!rst) begin
			bclk_s       <= '0;
			lrclk_s      <= '0;
			sdata_s      <= '0;
			bclk_d       <= 1'b0;
			// seen as high so the first left half counts as a change
			lr_last      <= 1'b1;
			shifting     <= 1'b0;
			bit_cnt      <= '0;
			sample_valid <= 1'b0;
		end else begin
			bclk_s       <= {bclk_s[0], bclk};
			lrclk_s      <= {lrclk_s[0], lrclk};
			sdata_s      <= {sdata_s[0], sdata};
			bclk_d       <= bclk_s[1];
			sample_valid <= 1'b0;
			if (bclk_rise) begin
				lr_last <= lrclk_s[1];
				// the rise that sees the change carries the old LSB, skip it
				if (lr_change) begin
					shifting <= 1'b1;
					bit_cnt  <= '0;
				end else if (shifting) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						shifting     <= 1'b0;
						sample_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bclk_rise) begin
			if (lr_change) begin
				chan <= lrclk_s[1];
			end else if (shifting) begin
				shift_reg <= {shift_reg[SAMPLE_W-2:0], sdata_s[1]};
			end
		end
	end

	assign sample = '{right: chan, sample: shift_reg};

endmodule

`default_nettype wire

/* rtl/i2s_pkg.sv */
`default_nettype none

package i2s_pkg;

	localparam int RX_NUM     = 2;
	localparam int SAMPLE_W   = 24;
	localparam int ID_W       = 5;
	localparam int WORD_W     = 32;
	localparam int FIFO_DEPTH = 16;
	localparam int OUT_WORDS  = 8;

	// derived sizes
	localparam int PAD_W     = WORD_W - ID_W - 1 - SAMPLE_W;
	localparam int PTR_W     = $clog2(FIFO_DEPTH);
	localparam int LEVEL_W   = $clog2(FIFO_DEPTH + 1);
	localparam int BIT_CNT_W = $clog2(SAMPLE_W);

	// host word, id in the top bits
	typedef struct packed {
		logic [ID_W-1:0]     id;
		logic                right;
		logic [PAD_W-1:0]    pad;
		logic [SAMPLE_W-1:0] sample;
	} rx_word_t;

	typedef struct packed {
		logic                right;
		logic [SAMPLE_W-1:0] sample;
	} mon_sample_t;

endpackage

`default_nettype wire
